// File: source/rb_config.svh
// constants for the spi register bank
// frame layout, register map, reset values and timing in cs cycles
// include wherever a constant is needed, the guard keeps repeats harmless
`ifndef RB_CONFIG_SVH
`define RB_CONFIG_SVH

// frame layout, flag bit then address then data, msb first
`define RB_FRAME_BITS     32
`define RB_ADDR_BITS      7
`define RB_DATA_BITS      24

// register map
`define RB_ADDR_LED       7
`define RB_ADDR_SPI_MUX   8
`define RB_ADDR_4094      9

// reset and filler values, cast to reg_data_t where used
`define RB_LED_RESET      'b10101
`define RB_BAD_ADDR_DATA  12345

// timing, all in cs cycles
`define RB_SPI_MIN_HALF   4     // shortest sclk half-period the slave keeps up with
`define RB_SR_REFRESH     512   // 4094 refresh period
`define RB_SR_HALF        2     // sr_clk half-period

`endif

// File: source/rb_pkg.sv
// shared types of the spi register bank
// vector types for register addresses and values, and the fsm encodings
// referenced by scoped names, e.g. rb_pkg::reg_data_t
`default_nettype none

`include "rb_config.svh"

package rb_pkg;

  typedef logic [`RB_ADDR_BITS-1:0] reg_addr_t;   // register address
  typedef logic [`RB_DATA_BITS-1:0] reg_data_t;   // register value

  // spi frame engine
  typedef enum logic [1:0] {
    SPI_IDLE,   // ss_n high, waiting for a frame
    SPI_ADDR,   // flag and address bits
    SPI_DATA,   // data bits, miso active
    SPI_END     // ss_n rose, finish any request
  } spi_state_t;

  // 4094 refresh driver
  typedef enum logic [1:0] {
    SR_WAIT,    // refresh timer running
    SR_FETCH,   // reading register 9
    SR_SHIFT,   // clocking bits into the chain
    SR_STROBE   // latch the chain outputs
  } sr_state_t;

endpackage

`default_nettype wire

// File: source/spi_frame_slave.sv
// spi mode 0 slave that turns 32-bit frames into register requests
// pins are synchronized and oversampled on cs, sclk is never used as a clock
// a read requests its address after 8 bits and returns the value on miso
// a write is issued after ss_n rises, only for a complete 32-bit frame
`default_nettype none
`timescale 1ns/1ps

`include "rb_config.svh"

module spi_frame_slave (
  input  wire logic              cs,
  input  wire logic              rst,
  input  wire logic              sclk,
  input  wire logic              ss_n,
  input  wire logic              mosi,
  input  wire logic              req_ready,
  input  wire logic              rsp_valid,
  input  wire rb_pkg::reg_data_t rsp_rdata,
  output logic                   miso,
  output logic                   req_valid,
  output logic                   req_write,
  output rb_pkg::reg_addr_t      req_addr,
  output rb_pkg::reg_data_t      req_wdata
);

  logic sclk_s1, sclk_s2, sclk_d;   // sclk sync chain plus edge history
  logic ss_s1, ss_s2, ss_d;
  logic mosi_s1, mosi_s2;
  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;
  logic last_addr_bit;              // 8th rising edge of the frame

  logic [`RB_FRAME_BITS-1:0]       frame_q;
  logic [`RB_FRAME_BITS-1:0]       frame_next;
  logic [$clog2(`RB_FRAME_BITS):0] bit_cnt;   // saturates, so long frames never match 32
  rb_pkg::reg_data_t               tx_q;      // miso shift register
  rb_pkg::spi_state_t              state;

  // two-flop synchronizers, ss_n idles high
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      {sclk_s1, sclk_s2, sclk_d} <= 3'b000;
      {ss_s1, ss_s2, ss_d}       <= 3'b111;
      {mosi_s1, mosi_s2}         <= 2'b00;
    end
    else
    begin
      {sclk_s1, sclk_s2, sclk_d} <= {sclk, sclk_s1, sclk_s2};
      {ss_s1, ss_s2, ss_d}       <= {ss_n, ss_s1, ss_s2};
      {mosi_s1, mosi_s2}         <= {mosi, mosi_s1};
    end
  end

  assign sclk_rise     = sclk_s2 & ~sclk_d;
  assign sclk_fall     = ~sclk_s2 & sclk_d;
  assign ss_rise       = ss_s2 & ~ss_d;
  assign frame_next    = {frame_q[`RB_FRAME_BITS-2:0], mosi_s2};   // msb first
  assign last_addr_bit = sclk_rise && (bit_cnt == `RB_ADDR_BITS);

  // frame fsm and request control
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state     <= rb_pkg::SPI_IDLE;
      bit_cnt   <= '0;
      req_valid <= 1'b0;
      req_write <= 1'b0;
      miso      <= 1'b0;
    end
    else
    begin
      if (req_valid && req_ready)
        req_valid <= 1'b0;                     // handshake done
      case (state)
        rb_pkg::SPI_IDLE:
        begin
          miso    <= 1'b0;
          bit_cnt <= '0;
          if (!ss_s2)
            state <= rb_pkg::SPI_ADDR;         // frame starts
        end
        rb_pkg::SPI_ADDR:
        begin
          if (ss_rise)
            state <= rb_pkg::SPI_END;          // aborted before the address was complete
          else if (sclk_rise)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_addr_bit)
            begin
              state <= rb_pkg::SPI_DATA;
              if (frame_next[`RB_ADDR_BITS])   // flag set means read
              begin
                req_valid <= 1'b1;
                req_write <= 1'b0;
              end
            end
          end
        end
        rb_pkg::SPI_DATA:
        begin
          if (ss_rise)
          begin
            state <= rb_pkg::SPI_END;
            // write only on an exact 32-bit frame with flag low
            if (bit_cnt == `RB_FRAME_BITS && !frame_q[`RB_FRAME_BITS-1])
            begin
              req_valid <= 1'b1;
              req_write <= 1'b1;
            end
          end
          else
          begin
            if (sclk_rise && bit_cnt != '1)
              bit_cnt <= bit_cnt + 1'b1;
            if (sclk_fall)
              miso <= tx_q[`RB_DATA_BITS-1];   // change after the falling edge
          end
        end
        rb_pkg::SPI_END:
        begin
          if (!req_valid || req_ready)
            state <= rb_pkg::SPI_IDLE;
        end
        default: state <= rb_pkg::SPI_IDLE;
      endcase
    end
  end

  // frame, miso data and request fields
  always_ff @(posedge cs)
  begin
    if (state == rb_pkg::SPI_IDLE)
      tx_q <= '0;                              // write frames shift out zeros
    else if (rsp_valid)
      tx_q <= rsp_rdata;                       // lands well before the first falling edge
    else if (state == rb_pkg::SPI_DATA && sclk_fall)
      tx_q <= tx_q << 1;

    if (sclk_rise && (state == rb_pkg::SPI_ADDR || state == rb_pkg::SPI_DATA))
      frame_q <= frame_next;

    if (state == rb_pkg::SPI_ADDR && last_addr_bit)
      req_addr <= frame_next[`RB_ADDR_BITS-1:0];                   // read address
    else if (state == rb_pkg::SPI_DATA && ss_rise)
    begin
      req_addr  <= frame_q[`RB_FRAME_BITS-2 -: `RB_ADDR_BITS];     // write address
      req_wdata <= frame_q[`RB_DATA_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/reg_arbiter.sv
// fixed-priority arbiter between the spi slave and the 4094 driver
// grant is combinational, the spi side always wins and never waits
// the read response arrives one cycle after the completing cycle
// and is routed back to whichever requester issued the read
`default_nettype none
`timescale 1ns/1ps

module reg_arbiter (
  input  wire logic              cs,
  input  wire logic              rst,
  input  wire logic              spi_req_valid,
  input  wire logic              spi_req_write,
  input  wire rb_pkg::reg_addr_t spi_req_addr,
  input  wire rb_pkg::reg_data_t spi_req_wdata,
  output logic                   spi_req_ready,
  output logic                   spi_rsp_valid,
  output rb_pkg::reg_data_t      spi_rsp_rdata,
  input  wire logic              drv_req_valid,
  input  wire logic              drv_req_write,
  input  wire rb_pkg::reg_addr_t drv_req_addr,
  input  wire rb_pkg::reg_data_t drv_req_wdata,
  output logic                   drv_req_ready,
  output logic                   drv_rsp_valid,
  output rb_pkg::reg_data_t      drv_rsp_rdata,
  output logic                   bus_valid,
  output logic                   bus_write,
  output rb_pkg::reg_addr_t      bus_addr,
  output rb_pkg::reg_data_t      bus_wdata,
  input  wire rb_pkg::reg_data_t bus_rdata
);

  logic grant_drv;   // driver wins only when spi is quiet
  logic rd_spi_q;    // spi read completed last cycle
  logic rd_drv_q;

  assign grant_drv     = drv_req_valid & ~spi_req_valid;
  assign spi_req_ready = 1'b1;                 // top priority, nothing blocks it
  assign drv_req_ready = ~spi_req_valid;

  assign bus_valid = spi_req_valid | drv_req_valid;
  assign bus_write = spi_req_valid ? spi_req_write : drv_req_write;
  assign bus_addr  = spi_req_valid ? spi_req_addr  : drv_req_addr;
  assign bus_wdata = spi_req_valid ? spi_req_wdata : drv_req_wdata;

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      rd_spi_q <= 1'b0;
      rd_drv_q <= 1'b0;
    end
    else
    begin
      rd_spi_q <= spi_req_valid & ~spi_req_write;
      rd_drv_q <= grant_drv & ~drv_req_write;
    end
  end

  // read data from reg_file is already a cycle late, matching the flags
  assign spi_rsp_valid = rd_spi_q;
  assign drv_rsp_valid = rd_drv_q;
  assign spi_rsp_rdata = rd_spi_q ? bus_rdata : '0;
  assign drv_rsp_rdata = rd_drv_q ? bus_rdata : '0;

endmodule

`default_nettype wire

// File: source/reg_file.sv
// the three 24-bit control registers behind the arbiter
// writes land on the completing edge, read data is registered one cycle
// unknown addresses read the filler value and ignore writes
// led and spi_mux leave as plain ports, register 9 is read by the 4094 driver
`default_nettype none
`timescale 1ns/1ps

`include "rb_config.svh"

module reg_file (
  input  wire logic              cs,
  input  wire logic              rst,
  input  wire logic              bus_valid,
  input  wire logic              bus_write,
  input  wire rb_pkg::reg_addr_t bus_addr,
  input  wire rb_pkg::reg_data_t bus_wdata,
  output rb_pkg::reg_data_t      bus_rdata,
  output rb_pkg::reg_data_t      led,
  output rb_pkg::reg_data_t      spi_mux
);

  rb_pkg::reg_data_t led_q;
  rb_pkg::reg_data_t mux_q;   // no spi device selected after reset
  rb_pkg::reg_data_t sr_q;    // 4094 output image

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      led_q <= rb_pkg::reg_data_t'(`RB_LED_RESET);
      mux_q <= '0;
      sr_q  <= '0;
    end
    else if (bus_valid && bus_write)
    begin
      case (bus_addr)
        `RB_ADDR_LED:     led_q <= bus_wdata;
        `RB_ADDR_SPI_MUX: mux_q <= bus_wdata;
        `RB_ADDR_4094:    sr_q  <= bus_wdata;
        default:          ;                    // unknown address, dropped
      endcase
    end
  end

  always_ff @(posedge cs)
  begin
    if (bus_valid && !bus_write)
    begin
      case (bus_addr)
        `RB_ADDR_LED:     bus_rdata <= led_q;
        `RB_ADDR_SPI_MUX: bus_rdata <= mux_q;
        `RB_ADDR_4094:    bus_rdata <= sr_q;
        default:          bus_rdata <= rb_pkg::reg_data_t'(`RB_BAD_ADDR_DATA);
      endcase
    end
  end

  assign led     = led_q;
  assign spi_mux = mux_q;

endmodule

`default_nettype wire

// File: source/sr4094_driver.sv
// periodic refresh of an external 74hc4094 chain from register 9
// every refresh period it reads the register through the arbiter,
// shifts the 24 bits out msb first on sr_clk rising edges,
// then pulses sr_strobe for one cycle to latch the chain outputs
`default_nettype none
`timescale 1ns/1ps

`include "rb_config.svh"

module sr4094_driver (
  input  wire logic              cs,
  input  wire logic              rst,
  input  wire logic              req_ready,
  input  wire logic              rsp_valid,
  input  wire rb_pkg::reg_data_t rsp_rdata,
  output logic                   req_valid,
  output logic                   req_write,
  output rb_pkg::reg_addr_t      req_addr,
  output rb_pkg::reg_data_t      req_wdata,
  output logic                   sr_clk,
  output logic                   sr_data,
  output logic                   sr_strobe
);

  logic [$clog2(`RB_SR_REFRESH)-1:0] refresh_cnt;
  logic                              refresh_tick;
  logic [$clog2(`RB_SR_HALF+1)-1:0]  half_cnt;
  logic                              half_done;     // end of an sr_clk half-period
  logic [$clog2(`RB_DATA_BITS)-1:0]  bit_cnt;
  rb_pkg::reg_data_t                 shift_q;
  rb_pkg::sr_state_t                 state;

  // read-only peer of the register file
  assign req_write = 1'b0;
  assign req_addr  = rb_pkg::reg_addr_t'(`RB_ADDR_4094);
  assign req_wdata = '0;

  assign refresh_tick = (refresh_cnt == `RB_SR_REFRESH - 1);
  assign half_done    = (half_cnt == `RB_SR_HALF - 1);

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state       <= rb_pkg::SR_WAIT;
      refresh_cnt <= '0;
      half_cnt    <= '0;
      bit_cnt     <= '0;
      req_valid   <= 1'b0;
      sr_clk      <= 1'b0;
      sr_data     <= 1'b0;
      sr_strobe   <= 1'b0;
    end
    else
    begin
      refresh_cnt <= refresh_tick ? '0 : refresh_cnt + 1'b1;   // free running
      case (state)
        rb_pkg::SR_WAIT:
        begin
          sr_data <= 1'b0;
          if (refresh_tick)
          begin
            req_valid <= 1'b1;
            state     <= rb_pkg::SR_FETCH;
          end
        end
        rb_pkg::SR_FETCH:
        begin
          if (req_valid && req_ready)
            req_valid <= 1'b0;                         // held while spi owns the bus
          if (rsp_valid)
          begin
            sr_data  <= rsp_rdata[`RB_DATA_BITS-1];    // first bit set up while sr_clk low
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rb_pkg::SR_SHIFT;
          end
        end
        rb_pkg::SR_SHIFT:
        begin
          if (!half_done)
            half_cnt <= half_cnt + 1'b1;
          else
          begin
            half_cnt <= '0;
            sr_clk   <= ~sr_clk;
            if (sr_clk)                                // falling edge, next bit
            begin
              sr_data <= shift_q[`RB_DATA_BITS-2];
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == `RB_DATA_BITS - 1)
                state <= rb_pkg::SR_STROBE;
            end
          end
        end
        rb_pkg::SR_STROBE:
        begin
          sr_strobe <= ~sr_strobe;                     // one idle cycle, then the pulse
          if (sr_strobe)
            state <= rb_pkg::SR_WAIT;
        end
        default: state <= rb_pkg::SR_WAIT;
      endcase
    end
  end

  always_ff @(posedge cs)
  begin
    if (state == rb_pkg::SR_FETCH && rsp_valid)
      shift_q <= rsp_rdata;
    else if (state == rb_pkg::SR_SHIFT && half_done && sr_clk)
      shift_q <= shift_q << 1;
  end

endmodule

`default_nettype wire

// File: source/spi_reg_bank_top.sv
// board controller register bank, spi slave in front of three registers
// the spi frame engine and the 4094 refresh driver share the register file
// through a fixed-priority arbiter, everything runs on cs
`default_nettype none
`timescale 1ns/1ps

module spi_reg_bank_top (
  input  wire logic         cs,
  input  wire logic         rst,
  input  wire logic         sclk,
  input  wire logic         ss_n,
  input  wire logic         mosi,
  output logic              miso,
  output rb_pkg::reg_data_t led,
  output rb_pkg::reg_data_t spi_mux,
  output logic              sr_clk,
  output logic              sr_data,
  output logic              sr_strobe
);

  // spi side requester
  logic              spi_req_valid, spi_req_write, spi_req_ready, spi_rsp_valid;
  rb_pkg::reg_addr_t spi_req_addr;
  rb_pkg::reg_data_t spi_req_wdata, spi_rsp_rdata;

  // 4094 driver requester
  logic              drv_req_valid, drv_req_write, drv_req_ready, drv_rsp_valid;
  rb_pkg::reg_addr_t drv_req_addr;
  rb_pkg::reg_data_t drv_req_wdata, drv_rsp_rdata;

  // register file port
  logic              bus_valid, bus_write;
  rb_pkg::reg_addr_t bus_addr;
  rb_pkg::reg_data_t bus_wdata, bus_rdata;

  spi_frame_slave spi_frame_slave_inst (
    .cs(cs), .rst(rst), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
    .req_valid(spi_req_valid), .req_write(spi_req_write), .req_addr(spi_req_addr),
    .req_wdata(spi_req_wdata), .req_ready(spi_req_ready),
    .rsp_valid(spi_rsp_valid), .rsp_rdata(spi_rsp_rdata)
  );

  sr4094_driver sr4094_driver_inst (
    .cs(cs), .rst(rst),
    .req_valid(drv_req_valid), .req_write(drv_req_write), .req_addr(drv_req_addr),
    .req_wdata(drv_req_wdata), .req_ready(drv_req_ready),
    .rsp_valid(drv_rsp_valid), .rsp_rdata(drv_rsp_rdata),
    .sr_clk(sr_clk), .sr_data(sr_data), .sr_strobe(sr_strobe)
  );

  reg_arbiter reg_arbiter_inst (
    .cs(cs), .rst(rst),
    .spi_req_valid(spi_req_valid), .spi_req_write(spi_req_write),
    .spi_req_addr(spi_req_addr), .spi_req_wdata(spi_req_wdata),
    .spi_req_ready(spi_req_ready), .spi_rsp_valid(spi_rsp_valid),
    .spi_rsp_rdata(spi_rsp_rdata),
    .drv_req_valid(drv_req_valid), .drv_req_write(drv_req_write),
    .drv_req_addr(drv_req_addr), .drv_req_wdata(drv_req_wdata),
    .drv_req_ready(drv_req_ready), .drv_rsp_valid(drv_rsp_valid),
    .drv_rsp_rdata(drv_rsp_rdata),
    .bus_valid(bus_valid), .bus_write(bus_write), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
  );

  reg_file reg_file_inst (
    .cs(cs), .rst(rst),
    .bus_valid(bus_valid), .bus_write(bus_write), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .led(led), .spi_mux(spi_mux)
  );

endmodule

`default_nettype wire

// File: testbench/spi_reg_bank_assert.sv
// protocol assertions for the register arbiter and the 4094 driver
// bound into the top level, where both requesters meet the arbiter
`default_nettype none
`timescale 1ns/1ps

module spi_reg_bank_assert (
  input wire logic cs,
  input wire logic rst,
  input wire logic spi_req_valid,
  input wire logic spi_req_write,
  input wire logic spi_req_ready,
  input wire logic spi_rsp_valid,
  input wire logic drv_req_valid,
  input wire logic drv_req_write,
  input wire logic drv_req_ready,
  input wire logic drv_rsp_valid,
  input wire logic sr_strobe
);

  // a stalled driver request stays up until granted
  a_drv_hold: assert property (@(posedge cs) disable iff (rst)
    drv_req_valid && !drv_req_ready |=> drv_req_valid)
    else $error("driver request dropped while stalled");

  // responses only one cycle after a completed read
  a_spi_rsp: assert property (@(posedge cs) disable iff (rst)
    spi_rsp_valid |-> $past(spi_req_valid && spi_req_ready && !spi_req_write))
    else $error("spi response without a completed read");

  a_drv_rsp: assert property (@(posedge cs) disable iff (rst)
    drv_rsp_valid |-> $past(drv_req_valid && drv_req_ready && !drv_req_write))
    else $error("driver response without a completed read");

  a_strobe: assert property (@(posedge cs) disable iff (rst)
    sr_strobe |=> !sr_strobe)   // latch pulse is one cycle wide
    else $error("sr_strobe held longer than one cycle");

endmodule

bind spi_reg_bank_top spi_reg_bank_assert spi_reg_bank_assert_inst (
  .cs(cs), .rst(rst),
  .spi_req_valid(spi_req_valid), .spi_req_write(spi_req_write),
  .spi_req_ready(spi_req_ready), .spi_rsp_valid(spi_rsp_valid),
  .drv_req_valid(drv_req_valid), .drv_req_write(drv_req_write),
  .drv_req_ready(drv_req_ready),
  .drv_rsp_valid(drv_rsp_valid), .sr_strobe(sr_strobe)
);

`default_nettype wire

// File: testbench/spi_reg_bank_tb.sv
// testbench for the spi register bank
// replays frames from the trace file through a bit-banged spi master,
// checks miso read data, the led and spi_mux ports and the 4094 chain word
`default_nettype none
`timescale 1ns/1ps

`include "rb_config.svh"

module spi_reg_bank_tb;

  localparam int HALF         = 6;   // sclk half-period in cs cycles
  localparam int FRAME_CYCLES = `RB_FRAME_BITS * 2 * HALF + 4 * HALF;
  localparam string TRACE     = "testbench/spi_reg_bank_trace.txt";

  logic              cs = 1'b0;
  logic              rst;
  logic              sclk;
  logic              ss_n;
  logic              mosi;
  logic              miso;
  rb_pkg::reg_data_t led;
  rb_pkg::reg_data_t spi_mux;
  logic              sr_clk;
  logic              sr_data;
  logic              sr_strobe;

  rb_pkg::reg_data_t m_led;   // register model, follows the trace writes
  rb_pkg::reg_data_t m_mux;
  rb_pkg::reg_data_t m_sr;

  rb_pkg::reg_data_t sr_shift;       // chain contents as seen by the 4094s
  rb_pkg::reg_data_t sr_word;        // last latched word
  logic              sr_clk_q;
  int                sr_bits;
  int                sr_word_bits;
  int                strobe_cnt;

  int err_cnt;
  int test_cnt;
  int fail_cnt;
  int limit;
  int cycles;

  always #10 cs = ~cs;   // 20 ns period

  spi_reg_bank_top spi_reg_bank_top_inst (
    .cs(cs), .rst(rst), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
    .led(led), .spi_mux(spi_mux),
    .sr_clk(sr_clk), .sr_data(sr_data), .sr_strobe(sr_strobe)
  );

  // 4094 side, sampled away from the cs rising edge
  always @(negedge cs)
  begin
    sr_clk_q <= sr_clk;
    if (rst)
    begin
      sr_bits    <= 0;
      strobe_cnt <= 0;
    end
    else
    begin
      if (sr_clk && !sr_clk_q)   // chain shifts on the sr_clk rise
      begin
        sr_shift <= {sr_shift[`RB_DATA_BITS-2:0], sr_data};
        sr_bits  <= sr_bits + 1;
      end
      if (sr_strobe)
      begin
        sr_word      <= sr_shift;
        sr_word_bits <= sr_bits;
        sr_bits      <= 0;
        strobe_cnt   <= strobe_cnt + 1;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH time %0t: %s is %h, expected %h", $time, name, actual, expected);
      err_cnt++;
    end
  endtask

  // mode 0 master, mosi set while sclk low, miso taken at the sclk rise
  task automatic send_frame(input int nbits, input logic [31:0] word,
                            output logic [31:0] rx);
    int i;
    rx = '0;
    @(posedge cs);
    ss_n <= 1'b0;
    repeat (HALF) @(posedge cs);
    for (i = 0; i < nbits; i++)
    begin
      mosi <= word[31-i];
      repeat (HALF) @(posedge cs);
      sclk <= 1'b1;
      @(negedge cs);
      rx = {rx[30:0], miso};   // slave moves miso only after a fall
      repeat (HALF) @(posedge cs);
      sclk <= 1'b0;
    end
    repeat (HALF) @(posedge cs);
    ss_n <= 1'b1;              // returns on the edge that raises ss_n
  endtask

  task automatic write_reg(input rb_pkg::reg_addr_t addr, input rb_pkg::reg_data_t data);
    logic [31:0] rx;
    send_frame(`RB_FRAME_BITS, {1'b0, addr, data}, rx);
    repeat (3) @(posedge cs);
    @(negedge cs);
    check_value("led", led, m_led);       // one cycle before the write lands
    check_value("spi_mux", spi_mux, m_mux);
    case (addr)
      `RB_ADDR_LED:     m_led = data;
      `RB_ADDR_SPI_MUX: m_mux = data;
      `RB_ADDR_4094:    m_sr  = data;
      default:          ;                 // unknown address stores nothing
    endcase
    @(posedge cs);
    @(negedge cs);
    check_value("led", led, m_led);
    check_value("spi_mux", spi_mux, m_mux);
  endtask

  task automatic read_reg(input rb_pkg::reg_addr_t addr, input rb_pkg::reg_data_t expected);
    logic [31:0] rx;
    send_frame(`RB_FRAME_BITS, {1'b1, addr, {`RB_DATA_BITS{1'b0}}}, rx);
    check_value("miso read data", rx[`RB_DATA_BITS-1:0], expected);
  endtask

  // frame cut off before 32 bits, registers must stay as they were
  task automatic cut_frame(input int nbits, input logic [31:0] word);
    logic [31:0] rx;
    send_frame(nbits, word, rx);
    repeat (4) @(posedge cs);
    @(negedge cs);
    check_value("led", led, m_led);
    check_value("spi_mux", spi_mux, m_mux);
  endtask

  // second strobe from now belongs to a fetch made after the last write
  task automatic verify_4094_word;
    int start;
    start = strobe_cnt;
    while (strobe_cnt < start + 2)
      @(negedge cs);
    check_value("4094 word", sr_word, m_sr);
    check_value("4094 bit count", sr_word_bits, `RB_DATA_BITS);
  endtask

  // one trace entry, comment lines starting with # are skipped
  task automatic next_entry(input int fd, output logic [7:0] op,
                            output logic [31:0] addr, data, value, output bit ok);
    logic [63:0]      tok;
    logic [8*128-1:0] rest;
    int               r;
    ok = 1'b0;
    op = 8'h00;
    r  = $fscanf(fd, "%s", tok);
    while (r == 1 && tok[7:0] == "#")
    begin
      r = $fgets(rest, fd);
      r = $fscanf(fd, "%s", tok);
    end
    if (r == 1)
    begin
      op = tok[7:0];
      r  = $fscanf(fd, "%h %h %h", addr, data, value);
      ok = (r == 3);
    end
  endtask

  task automatic apply_entry(input logic [7:0] op, input logic [31:0] addr, data, value);
    case (op)
      "W": write_reg(addr[6:0], data[23:0]);
      "R": read_reg(addr[6:0], value[23:0]);
      "C": cut_frame(int'(value), {1'b0, addr[6:0], data[23:0]});
      "P": verify_4094_word;
      "H":
      begin
        @(negedge cs);
        while (!sr_clk)          // wait until a refresh is shifting
          @(negedge cs);
        read_reg(addr[6:0], value[23:0]);
      end
      default:
      begin
        $display("unknown operation %c in the trace", op);
        err_cnt++;
      end
    endcase
  endtask

  initial
  begin
    int          fd;
    int          n_ops;
    int          errs_before;
    bit          ok;
    logic [7:0]  op;
    logic [31:0] addr, data, value;
    err_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    n_ops    = 0;
    limit    = 1000;
    rst      = 1'b1;
    sclk     = 1'b0;
    ss_n     = 1'b1;
    mosi     = 1'b0;
    m_led    = rb_pkg::reg_data_t'(`RB_LED_RESET);
    m_mux    = '0;
    m_sr     = '0;
    fd = $fopen(TRACE, "r");
    if (fd == 0)
    begin
      $display("cannot open the trace file %s", TRACE);
      err_cnt++;
    end
    else
    begin
      next_entry(fd, op, addr, data, value, ok);   // first pass only counts frames
      while (ok)
      begin
        n_ops++;
        next_entry(fd, op, addr, data, value, ok);
      end
      $fclose(fd);
      limit = 40 + n_ops * (FRAME_CYCLES + 2 * `RB_SR_REFRESH + 4 * HALF);
      repeat (10) @(posedge cs);
      rst <= 1'b0;
      repeat (HALF) @(posedge cs);
      fd = $fopen(TRACE, "r");
      next_entry(fd, op, addr, data, value, ok);
      while (ok)
      begin
        errs_before = err_cnt;
        apply_entry(op, addr, data, value);
        test_cnt++;
        if (err_cnt != errs_before)
          fail_cnt++;
        $display("test %0d: %c addr %h data %h: %s", test_cnt, op, addr[6:0], data[23:0],
                 (err_cnt == errs_before) ? "ok" : "wrong");
        repeat (HALF) @(posedge cs);   // short idle gap, frames stay back to back
        next_entry(fd, op, addr, data, value, ok);
      end
      $fclose(fd);
      if (test_cnt == 0)
      begin
        $display("the trace file held no frames");
        err_cnt++;
      end
    end
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog, limit is set from the frame count before the first edge
  initial
  begin
    cycles = 0;
    @(posedge cs);
    while (cycles < limit)
    begin
      @(posedge cs);
      cycles++;
    end
    $display("timeout: run still busy after %0d cs cycles", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/rb_pkg.sv
source/spi_frame_slave.sv
source/reg_arbiter.sv
source/reg_file.sv
source/sr4094_driver.sv
source/spi_reg_bank_top.sv
testbench/spi_reg_bank_assert.sv
testbench/spi_reg_bank_tb.sv

// File: testbench/spi_reg_bank_trace.txt
# op addr data value, all hex; W write, R read with expected value, C cut frame of value bits
# P waits for a fresh 4094 word and compares it with register 9, H reads during a refresh
R 07 000000 000015
R 08 000000 000000
R 09 000000 000000
W 07 a5c3e1 000000
R 07 000000 a5c3e1
W 08 00000c 000000
R 08 000000 00000c
W 09 c0ffee 000000
R 09 000000 c0ffee
R 2a 000000 003039
R 00 000000 003039
W 2a 777777 000000
R 07 000000 a5c3e1
R 08 000000 00000c
C 07 123456 000005
C 08 654321 000014
C 09 abcdef 00001f
R 09 000000 c0ffee
P 00 000000 000000
W 09 5a0f3c 000000
P 00 000000 000000
H 09 000000 5a0f3c
H 07 000000 a5c3e1
H 08 000000 00000c
